/* hw/conv_pkg.sv */
// Convolution engine package
// Fixed sizes and widths of the datapath, and the per-beat control word
// that travels from the shift buffer to the convolution units

package conv_pkg;

    // Parallel units, one output row each
    localparam int conv_units   = 4;

    // Kernel limits
    localparam int kernel_w_max = 3;
    localparam int kernel_h_max = 3;

    // One input column covers every unit plus the kernel overlap
    localparam int col_pixels   = conv_units + kernel_h_max - 1;

    // Signed pixel and weight width
    localparam int data_w       = 8;

    // Accumulator width, enough for a full 3x3 sum of 8-bit products
    localparam int acc_w        = 20;

    // Output word width after saturation
    localparam int out_w        = 16;

    // Image width limit and counter widths
    localparam int cols_max     = 16;
    localparam int cols_w       = $clog2(cols_max);
    localparam int kw_w         = $clog2(kernel_w_max);
    localparam int kh_w         = $clog2(kernel_h_max);

    // Per-beat control word
    // Raw view is assembled by the shift buffer, flags are read by the units
    typedef union packed {
        logic [3:0] raw;
        struct packed {
            logic is_relu;
            logic first_row;
            logic last_row;
            logic fill_col;
        } flags;
    } beat_ctrl_t;

endpackage

/* hw/pix_beat_if.sv */
// Row beat interface
// Carries one kernel row of pixels per beat from the shift buffer to
// all convolution units, with the beat control word and last column flag

interface pix_beat_if;

    logic                                valid;
    logic                                ready;
    logic signed [conv_pkg::data_w-1:0]  pixels [conv_pkg::conv_units];
    conv_pkg::beat_ctrl_t                ctrl;
    // Beat belongs to the final image column
    logic                                last_col;

    modport src (
        output valid,
        output pixels,
        output ctrl,
        output last_col,
        input  ready
    );

    modport dst (
        input  valid,
        input  ready,
        input  pixels,
        input  ctrl,
        input  last_col
    );

endinterface

/* hw/shift_buffer.sv */
// Pixel shift buffer
// Holds one input column and replays it as kernel-height row beats,
// shifting the window down by one row per beat. Tracks the column
// position to flag fill columns and the final column of the image.

module shift_buffer (
    input  logic                               aclk,
    input  logic                               aclken,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic [conv_pkg::kh_w-1:0]          kernel_h_1,
    input  logic [conv_pkg::cols_w-1:0]        cols_1,
    input  logic                               is_relu,
    input  logic                               pixels_valid,
    input  logic signed [conv_pkg::data_w-1:0] pixels [conv_pkg::col_pixels],
    output logic                               pixels_ready,
    pix_beat_if.src                            beat,
    input  logic [conv_pkg::kw_w-1:0]          kernel_w_1
);

    logic signed [conv_pkg::data_w-1:0] col_q [conv_pkg::col_pixels];

    logic                        busy;
    logic [conv_pkg::kh_w-1:0]   row_cnt;
    logic [conv_pkg::cols_w-1:0] col_cnt;

    logic                        col_take;
    logic                        beat_take;
    logic                        row_end;
    logic                        fill;
    conv_pkg::beat_ctrl_t        ctrl_word;

    assign col_take  = pixels_valid && pixels_ready && aclken;
    assign beat_take = beat.valid && beat.ready && aclken;
    assign row_end   = (row_cnt == kernel_h_1);

    // First kw-1 columns only prime the accumulator chain
    assign fill = (col_cnt < {{(conv_pkg::cols_w - conv_pkg::kw_w){1'b0}}, kernel_w_1});

    // Column storage
    always_ff @(posedge aclk) begin
        if (col_take) begin
            col_q <= pixels;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (aclken) begin
            if (col_take) begin
                busy    <= 1'b1;
                row_cnt <= '0;
            end else if (beat_take) begin
                if (row_end) begin
                    busy    <= 1'b0;
                    col_cnt <= col_cnt + 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
            // New image restarts the column count
            if (start) begin
                col_cnt <= '0;
            end
        end
    end

    assign pixels_ready  = !busy;
    assign beat.valid    = busy;
    assign beat.last_col = (col_cnt == cols_1);

    always_comb begin
        ctrl_word.raw = {is_relu, (row_cnt == '0), row_end, fill};
    end

    assign beat.ctrl = ctrl_word;

    // Unit u sees row u + r of the column on row beat r
    always_comb begin
        for (int u = 0; u < conv_pkg::conv_units; u++) begin
            beat.pixels[u] = col_q[u + int'(row_cnt)];
        end
    end

endmodule

/* hw/conv_unit.sv */
// Convolution unit
// Computes one output row. Each row beat is multiplied by the weight row,
// the products collect in a transposed chain across the kernel width,
// and completed sums are saturated and optionally passed through ReLU.

module conv_unit #(
    parameter int unit_id = 0
) (
    input  logic                               aclk,
    input  logic                               aclken,
    input  logic                               arst_n,
    input  logic [conv_pkg::kw_w-1:0]          kernel_w_1,
    input  logic signed [conv_pkg::data_w-1:0] weights [conv_pkg::kernel_w_max],
    pix_beat_if.dst                            beat,
    output logic                               m_valid,
    output logic signed [conv_pkg::out_w-1:0]  m_data,
    output logic                               m_last_col
);

    logic                              fire;
    logic signed [conv_pkg::acc_w-1:0] px_ext;
    logic signed [conv_pkg::acc_w-1:0] w_ext [conv_pkg::kernel_w_max];

    logic                              p_valid;
    conv_pkg::beat_ctrl_t              p_ctrl;
    logic                              p_last_col;
    logic signed [conv_pkg::acc_w-1:0] prod [conv_pkg::kernel_w_max];

    logic signed [conv_pkg::acc_w-1:0] acc [conv_pkg::kernel_w_max];
    logic signed [conv_pkg::acc_w-1:0] tot [conv_pkg::kernel_w_max];
    logic [conv_pkg::acc_w-conv_pkg::out_w:0] hi_bits;
    logic signed [conv_pkg::out_w-1:0] sat_val;
    logic signed [conv_pkg::out_w-1:0] res_val;

    assign fire   = beat.valid && beat.ready && aclken;
    assign px_ext = {{(conv_pkg::acc_w - conv_pkg::data_w){beat.pixels[unit_id][conv_pkg::data_w-1]}},
                     beat.pixels[unit_id]};

    // Chain position j takes weight kw-1-j, unused positions get zero
    always_comb begin : pick_weights
        logic signed [conv_pkg::data_w-1:0] w_pick;
        for (int j = 0; j < conv_pkg::kernel_w_max; j++) begin
            w_pick = '0;
            if (j <= int'(kernel_w_1)) begin
                w_pick = weights[int'(kernel_w_1) - j];
            end
            w_ext[j] = {{(conv_pkg::acc_w - conv_pkg::data_w){w_pick[conv_pkg::data_w-1]}}, w_pick};
        end
    end

    // Product stage
    always_ff @(posedge aclk) begin
        if (fire) begin
            for (int j = 0; j < conv_pkg::kernel_w_max; j++) begin
                prod[j] <= px_ext * w_ext[j];
            end
            p_ctrl     <= beat.ctrl;
            p_last_col <= beat.last_col;
        end
    end

    // Entry position starts fresh on the first row of a column
    always_comb begin
        for (int p = 0; p < conv_pkg::kernel_w_max; p++) begin
            if (p_ctrl.flags.first_row && p == int'(kernel_w_1)) begin
                tot[p] = prod[p];
            end else begin
                tot[p] = acc[p] + prod[p];
            end
        end
    end

    // Saturate position 0 to the output range, then ReLU
    always_comb begin
        hi_bits = tot[0][conv_pkg::acc_w-1:conv_pkg::out_w-1];
        if (&hi_bits || ~|hi_bits) begin
            sat_val = tot[0][conv_pkg::out_w-1:0];
        end else if (tot[0][conv_pkg::acc_w-1]) begin
            sat_val = {1'b1, {(conv_pkg::out_w - 1){1'b0}}};
        end else begin
            sat_val = {1'b0, {(conv_pkg::out_w - 1){1'b1}}};
        end
        res_val = sat_val;
        if (p_ctrl.flags.is_relu && sat_val[conv_pkg::out_w-1]) begin
            res_val = '0;
        end
    end

    // Chain shift toward position 0 at the end of each column
    always_ff @(posedge aclk) begin
        if (aclken && p_valid) begin
            if (p_ctrl.flags.last_row) begin
                for (int p = 0; p < conv_pkg::kernel_w_max - 1; p++) begin
                    acc[p] <= tot[p + 1];
                end
                acc[conv_pkg::kernel_w_max-1] <= '0;
                m_data <= res_val;
            end else begin
                for (int p = 0; p < conv_pkg::kernel_w_max; p++) begin
                    acc[p] <= tot[p];
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            p_valid    <= 1'b0;
            m_valid    <= 1'b0;
            m_last_col <= 1'b0;
        end else if (aclken) begin
            p_valid    <= beat.valid && beat.ready;
            m_valid    <= p_valid && p_ctrl.flags.last_row && !p_ctrl.flags.fill_col;
            m_last_col <= p_valid && p_ctrl.flags.last_row && p_last_col;
        end
    end

endmodule

/* hw/conv_engine.sv */
// 2-D convolution engine
// Latches the layer configuration on start, joins the weight stream
// with the row beats of the shift buffer, and runs four convolution
// units in parallel, one output row each.

module conv_engine (
    input  logic                               aclk,
    input  logic                               aclken,
    input  logic                               arst_n,
    input  logic                               start,
    input  logic [conv_pkg::kw_w-1:0]          kernel_w_1,
    input  logic [conv_pkg::kh_w-1:0]          kernel_h_1,
    input  logic [conv_pkg::cols_w-1:0]        cols_1,
    input  logic                               is_relu,
    input  logic                               pixels_valid,
    input  logic signed [conv_pkg::data_w-1:0] pixels [conv_pkg::col_pixels],
    output logic                               pixels_ready,
    input  logic                               weights_valid,
    input  logic signed [conv_pkg::data_w-1:0] weights [conv_pkg::kernel_w_max],
    output logic                               weights_ready,
    output logic                               m_valid,
    output logic signed [conv_pkg::out_w-1:0]  m_data [conv_pkg::conv_units],
    output logic                               m_last,
    output logic                               done
);

    logic [conv_pkg::kw_w-1:0]   kernel_w_1_q;
    logic [conv_pkg::kh_w-1:0]   kernel_h_1_q;
    logic [conv_pkg::cols_w-1:0] cols_1_q;
    logic                        is_relu_q;

    logic unit_valid    [conv_pkg::conv_units];
    logic unit_last_col [conv_pkg::conv_units];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            kernel_w_1_q <= '0;
            kernel_h_1_q <= '0;
            cols_1_q     <= '0;
            is_relu_q    <= 1'b0;
        end else if (aclken && start) begin
            kernel_w_1_q <= kernel_w_1;
            kernel_h_1_q <= kernel_h_1;
            cols_1_q     <= cols_1;
            is_relu_q    <= is_relu;
        end
    end

    pix_beat_if beat ();

    // Join of row beats and weight rows
    assign beat.ready    = weights_valid;
    assign weights_ready = beat.valid;

    shift_buffer shift_buffer_i (
        .aclk         (aclk),
        .aclken       (aclken),
        .arst_n       (arst_n),
        .start        (start),
        .kernel_h_1   (kernel_h_1_q),
        .cols_1       (cols_1_q),
        .is_relu      (is_relu_q),
        .pixels_valid (pixels_valid),
        .pixels       (pixels),
        .pixels_ready (pixels_ready),
        .beat         (beat),
        .kernel_w_1   (kernel_w_1_q)
    );

    for (genvar i = 0; i < conv_pkg::conv_units; i++) begin : g_unit
        conv_unit #(
            .unit_id (i)
        ) conv_unit_i (
            .aclk       (aclk),
            .aclken     (aclken),
            .arst_n     (arst_n),
            .kernel_w_1 (kernel_w_1_q),
            .weights    (weights),
            .beat       (beat),
            .m_valid    (unit_valid[i]),
            .m_data     (m_data[i]),
            .m_last_col (unit_last_col[i])
        );
    end

    // All units run in lockstep, unit 0 speaks for them
    assign m_valid = unit_valid[0];
    assign m_last  = unit_valid[0] && unit_last_col[0];
    assign done    = unit_last_col[0];

endmodule

/* bench/conv_engine_tb.sv */
// Convolution engine testbench
// Replays test records from a data file through the pixel and weight
// streams with random gaps and clock-enable stalls, then checks every
// output word, m_last and done against the stored results

module conv_engine_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                               aclk;
    logic                               aclken;
    logic                               arst_n;
    logic                               start;
    logic [conv_pkg::kw_w-1:0]          kernel_w_1;
    logic [conv_pkg::kh_w-1:0]          kernel_h_1;
    logic [conv_pkg::cols_w-1:0]        cols_1;
    logic                               is_relu;
    logic                               pixels_valid;
    logic signed [conv_pkg::data_w-1:0] pixels [conv_pkg::col_pixels];
    logic                               pixels_ready;
    logic                               weights_valid;
    logic signed [conv_pkg::data_w-1:0] weights [conv_pkg::kernel_w_max];
    logic                               weights_ready;
    logic                               m_valid;
    logic signed [conv_pkg::out_w-1:0]  m_data [conv_pkg::conv_units];
    logic                               m_last;
    logic                               done;

    logic [15:0] tdata [256];
    int          ptr;
    int          seed = 9963;
    int          errors;
    int          failed_tests;
    int          cycle_cnt;
    int          cycle_limit = 1000000;

    conv_engine conv_engine_i (.*);

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the engine never finished a test", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // Total row beats over all records
    function automatic int count_beats();
        int p, w, k, c, b;
        p = 1;
        b = 0;
        for (int n = 0; n < int'(tdata[0]); n++) begin
            w = int'(tdata[p]) + 1;
            k = int'(tdata[p+1]) + 1;
            c = int'(tdata[p+2]) + 1;
            b += c * k;
            p += 4 + c * conv_pkg::col_pixels + k * conv_pkg::kernel_w_max
                 + (c - w + 1) * conv_pkg::conv_units;
        end
        return b;
    endfunction

    task automatic run_test(input int t);
        int rec, kw, kh, cols, n_out, px_base, w_base, exp_base;
        int col_i, beat_i, out_i, done_cnt, errs_before, beats_left;
        logic px_fire, w_fire, last_exp, rdy_exp;
        rec = ptr;
        kw = int'(tdata[rec]) + 1;
        kh = int'(tdata[rec+1]) + 1;
        cols = int'(tdata[rec+2]) + 1;
        n_out = cols - kw + 1;
        px_base = rec + 4;
        w_base = px_base + cols * conv_pkg::col_pixels;
        exp_base = w_base + kh * conv_pkg::kernel_w_max;
        ptr = exp_base + n_out * conv_pkg::conv_units;
        col_i = 0;
        beat_i = 0;
        out_i = 0;
        done_cnt = 0;
        beats_left = 0;
        errs_before = errors;
        px_fire = 1'b0;
        w_fire = 1'b0;
        // Start needs an enabled edge to latch the configuration
        aclken = 1'b1;
        start = 1'b1;
        kernel_w_1 = tdata[rec][conv_pkg::kw_w-1:0];
        kernel_h_1 = tdata[rec+1][conv_pkg::kh_w-1:0];
        cols_1 = tdata[rec+2][conv_pkg::cols_w-1:0];
        is_relu = tdata[rec+3][0];
        @(posedge aclk);
        #1;
        start = 1'b0;
        while (done_cnt == 0) begin
            if (px_fire) begin
                col_i++;
                beats_left = kh;
                pixels_valid = 1'b0;
            end
            if (w_fire) begin
                beat_i++;
                beats_left--;
                weights_valid = 1'b0;
            end
            aclken = ($random(seed) & 7) != 0;
            if (!pixels_valid && col_i < cols) begin
                pixels_valid = ($random(seed) & 3) != 0;
            end
            if (!weights_valid && beat_i < cols * kh) begin
                weights_valid = ($random(seed) & 3) != 0;
            end
            for (int i = 0; i < conv_pkg::col_pixels; i++) begin
                pixels[i] = tdata[px_base + (col_i % cols) * conv_pkg::col_pixels + i][7:0];
            end
            for (int k = 0; k < conv_pkg::kernel_w_max; k++) begin
                weights[k] = tdata[w_base + (beat_i % kh) * conv_pkg::kernel_w_max + k][7:0];
            end
            // Mid-cycle view equals what the next rising edge sees
            @(negedge aclk);
            // Column is held until all its row beats are taken
            rdy_exp = (beats_left == 0);
            if (pixels_ready !== rdy_exp) begin
                $display("** Error test %0d: pixels_ready = %h, expected %h",
                         t, pixels_ready, rdy_exp);
                errors++;
            end
            if (weights_ready !== !rdy_exp) begin
                $display("** Error test %0d: weights_ready = %h, expected %h",
                         t, weights_ready, !rdy_exp);
                errors++;
            end
            px_fire = pixels_valid && pixels_ready && aclken;
            w_fire = weights_valid && weights_ready && aclken;
            if (m_valid && aclken) begin
                if (out_i >= n_out) begin
                    $display("test %0d: output arrived beyond the expected %0d", t, n_out);
                    errors++;
                end else begin
                    for (int u = 0; u < conv_pkg::conv_units; u++) begin
                        if (m_data[u] !== tdata[exp_base + out_i * conv_pkg::conv_units + u]) begin
                            $display("** Error test %0d output %0d: m_data[%0d] = %h, expected %h",
                                     t, out_i, u, m_data[u],
                                     tdata[exp_base + out_i * conv_pkg::conv_units + u]);
                            errors++;
                        end
                    end
                    last_exp = (out_i == n_out - 1);
                    if (m_last !== last_exp) begin
                        $display("** Error test %0d output %0d: m_last = %h, expected %h",
                                 t, out_i, m_last, last_exp);
                        errors++;
                    end
                end
                out_i++;
            end
            if (done && aclken) begin
                done_cnt++;
                if (out_i != n_out) begin
                    $display("test %0d: done pulsed after %0d outputs, expected %0d",
                             t, out_i, n_out);
                    errors++;
                end
            end
            @(posedge aclk);
            #1;
        end
        pixels_valid = 1'b0;
        weights_valid = 1'b0;
        aclken = 1'b1;
        // Nothing more may follow the final output
        repeat (4) begin
            @(negedge aclk);
            if (done) begin
                done_cnt++;
            end
            if (m_valid) begin
                $display("test %0d: extra output after done", t);
                errors++;
            end
            @(posedge aclk);
            #1;
        end
        if (done_cnt != 1) begin
            $display("test %0d: done pulsed %0d times instead of once", t, done_cnt);
            errors++;
        end
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test %0d: kernel %0dx%0d, %0d columns, relu %0d, %0d outputs, %s",
                 t, kh, kw, cols, is_relu, out_i, (errors == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        aclken = 1'b1;
        arst_n = 1'b0;
        start = 1'b0;
        kernel_w_1 = '0;
        kernel_h_1 = '0;
        cols_1 = '0;
        is_relu = 1'b0;
        pixels_valid = 1'b0;
        weights_valid = 1'b0;
        for (int i = 0; i < conv_pkg::col_pixels; i++) begin
            pixels[i] = '0;
        end
        for (int k = 0; k < conv_pkg::kernel_w_max; k++) begin
            weights[k] = '0;
        end
        errors = 0;
        failed_tests = 0;
        $readmemh("bench/conv_testdata.mem", tdata);
        cycle_limit = 40 * count_beats();
        repeat (4) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        ptr = 1;
        for (int t = 1; t <= int'(tdata[0]); t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", int'(tdata[0]), failed_tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* bench/conv_testdata.mem */
// Words: test count, then per test kw-1 kh-1 cols-1 relu, pixel columns of
// 6 rows each, kh weight rows of 3, then expected outputs of 4 units each
3
// 3x3 kernel, 8 columns, ReLU off
2 2 7 0
0A 03 FC F5 EE E7  0F 08 01 FA F3 EC  14 0D 06 FF F8 F1
19 12 0B 04 FD F6  1E 17 10 09 02 FB  23 1C 15 0E 07 00
28 21 1A 13 0C 05  2D 26 1F 18 11 0A
01 02 FF  00 03 FE  FF 01 02
0023 0000 FFDD FFBA  003C 0019 FFF6 FFD3  0055 0032 000F FFEC
006E 004B 0028 0005  0087 0064 0041 001E  00A0 007D 005A 0037
// Same image and kernel, ReLU on
2 2 7 1
0A 03 FC F5 EE E7  0F 08 01 FA F3 EC  14 0D 06 FF F8 F1
19 12 0B 04 FD F6  1E 17 10 09 02 FB  23 1C 15 0E 07 00
28 21 1A 13 0C 05  2D 26 1F 18 11 0A
01 02 FF  00 03 FE  FF 01 02
0023 0000 0000 0000  003C 0019 0000 0000  0055 0032 000F 0000
006E 004B 0028 0005  0087 0064 0041 001E  00A0 007D 005A 0037
// 2x2 kernel, 5 columns, sums past the 16-bit range
1 1 4 0
64 64 EC 88 3C 00  65 65 ED 89 3D 01  66 66 EE 8A 3E 02
67 67 EF 8B 3F 03  68 68 F0 8C 40 04
7F 7F 00  7F 7F 00
7FFF 505E 8000 C576  7FFF 525A 8000 C772
7FFF 5456 8000 C96E  7FFF 5652 8000 CB6A

/* vlog.f */
hw/conv_pkg.sv
hw/pix_beat_if.sv
hw/shift_buffer.sv
hw/conv_unit.sv
hw/conv_engine.sv
bench/conv_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the convolution engine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module conv_engine_tb -o conv_engine_sim
./obj_dir/conv_engine_sim | tee sim.log
if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
